//--- flist.f
verilog/rv_pkg.sv
verilog/rv_regfile.sv
verilog/rv_alu.sv
verilog/rv_decode.sv
verilog/rv_execute.sv
verilog/rv_memory.sv
verilog/rv_core.sv
verification/tb_rv_core_assert.sv
verification/tb_rv_core.sv

//--- Bender.yml
package:
  name: rv_core

sources:
  - files:
      - verilog/rv_pkg.sv
      - verilog/rv_regfile.sv
      - verilog/rv_alu.sv
      - verilog/rv_decode.sv
      - verilog/rv_execute.sv
      - verilog/rv_memory.sv
      - verilog/rv_core.sv
  - target: test
    files:
      - verification/tb_rv_core_assert.sv
      - verification/tb_rv_core.sv

//--- verification/tb_rv_core.sv
// tb_rv_core
// testbench for the five-stage RV32I core, builds programs with encoder
// functions, runs an ISA reference model and checks every IO store

`timescale 1ns/1ns

module tb_rv_core;
   import rv_pkg::*;

   localparam int DMEM_WORDS = 1024;
   localparam int TIMEOUT    = 5000;  // cycles per test

   logic       clk = 1'b0;
   logic       resetn;
   imem_addr_t imem_addr;
   word_t      imem_data;
   word_t      io_addr;
   word_t      io_wdata;
   logic       io_wr;

   word_t  prog [1024];
   int     prog_len = 0;
   word_t  exp_addr [$];   // expected IO stores, in order
   word_t  exp_data [$];
   string  test_name;
   integer seed = 69;

   rv_core #(.DMEM_WORDS(DMEM_WORDS)) i_rv_core (
      .clk(clk), .resetn(resetn), .imem_addr(imem_addr), .imem_data(imem_data),
      .io_addr(io_addr), .io_wdata(io_wdata), .io_wr(io_wr)
   );

   bind rv_core tb_rv_core_assert i_rv_core_assert (
      .clk(clk), .resetn(resetn), .io_wr(io_wr), .io_addr(io_addr),
      .imem_data(imem_data), .redirect(redirect), .redirect_pc(redirect_pc),
      .imem_addr(imem_addr)
   );

   // program store, NOPs past the end of the program
   assign imem_data = (imem_addr < prog_len) ? prog[imem_addr] : NOP_INSTR;

   initial forever #2 clk = ~clk;

   function automatic word_t enc_r(logic [6:0] f7, reg_id_t rs2, reg_id_t rs1, funct3_t f3,
                                   reg_id_t rd);
      return {f7, rs2, rs1, f3, rd, 7'b0110011};
   endfunction

   function automatic word_t enc_i(logic [11:0] imm, reg_id_t rs1, funct3_t f3, reg_id_t rd,
                                   logic [6:0] op);
      return {imm, rs1, f3, rd, op};
   endfunction

   function automatic word_t enc_s(logic [11:0] imm, reg_id_t rs2, reg_id_t rs1);
      return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], 7'b0100011};  // sw
   endfunction

   function automatic word_t enc_b(logic [12:0] imm, reg_id_t rs2, reg_id_t rs1, funct3_t f3);
      return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], 7'b1100011};
   endfunction

   function automatic word_t enc_u(logic [19:0] imm, reg_id_t rd, logic [6:0] op);
      return {imm, rd, op};
   endfunction

   function automatic word_t enc_j(logic [20:0] imm, reg_id_t rd);
      return {imm[20], imm[10:1], imm[11], imm[19:12], rd, 7'b1101111};
   endfunction

   function automatic void put(word_t w);
      prog[prog_len] = w;
      prog_len++;
   endfunction

   // register write, then three NOPs before any reader
   function automatic void put_wr(word_t w);
      put(w);
      repeat (3) put(NOP_INSTR);
   endfunction

   function automatic void load_const(reg_id_t rd, word_t v);
      put_wr(enc_u(v[31:12] + v[11], rd, 7'b0110111));  // rounded for the signed addi
      put_wr(enc_i(v[11:0], rd, 3'b000, rd, 7'b0010011));
   endfunction

   function automatic void store_io(reg_id_t rs, logic [11:0] off);
      put(enc_s(off, rs, 5'd31));  // x31 holds the IO page base
   endfunction

   function automatic word_t alu_ref(funct3_t f3, logic alt, word_t a, word_t b);
      case (f3)
         3'd0:    return alt ? a - b : a + b;
         3'd1:    return a << b[4:0];
         3'd2:    return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
         3'd3:    return (a < b) ? 32'd1 : 32'd0;
         3'd4:    return a ^ b;
         3'd5: begin
            if (alt) begin
               return $signed(a) >>> b[4:0];
            end else begin
               return a >> b[4:0];
            end
         end
         3'd6:    return a | b;
         default: return a & b;
      endcase
   endfunction

   function automatic logic branch_ref(funct3_t f3, word_t a, word_t b);
      case (f3)
         3'd0:    return a == b;
         3'd1:    return a != b;
         3'd4:    return $signed(a) < $signed(b);
         3'd5:    return $signed(a) >= $signed(b);
         3'd6:    return a < b;
         3'd7:    return a >= b;
         default: return 1'b0;
      endcase
   endfunction

   // ISA model of the program, fills the expected IO store queues
   function automatic void run_model();
      word_t x [32];
      word_t mem [DMEM_WORDS];
      word_t pc;
      word_t ins;
      word_t a;
      word_t b;
      word_t imm_i;
      word_t ea;
      word_t res;
      word_t next_pc;
      logic  wb;
      int    steps;
      foreach (x[i]) x[i] = '0;
      foreach (mem[i]) mem[i] = '0;
      pc    = '0;
      steps = 0;
      while (pc < prog_len * 4 && steps < 4 * TIMEOUT) begin
         ins     = prog[pc[15:2]];
         a       = x[ins[19:15]];
         b       = x[ins[24:20]];
         imm_i   = {{20{ins[31]}}, ins[31:20]};
         ea      = a + imm_i;  // load address, jalr target
         res     = pc + 4;     // link value
         wb      = 1'b1;
         next_pc = pc + 4;
         case (ins[6:0])
            7'b0110011: res = alu_ref(ins[14:12], ins[30], a, b);
            7'b0010011: res = alu_ref(ins[14:12], ins[30] && ins[14:12] == 3'd5, a, imm_i);
            7'b0110111: res = {ins[31:12], 12'b0};
            7'b0010111: res = pc + {ins[31:12], 12'b0};
            7'b1101111: next_pc = pc + {{12{ins[31]}}, ins[19:12], ins[20], ins[30:21], 1'b0};
            7'b1100111: next_pc = ea & ~32'd1;
            7'b0000011: res = mem[(ea >> 2) % DMEM_WORDS];
            7'b0100011: begin
               wb = 1'b0;
               ea = a + {{20{ins[31]}}, ins[31:25], ins[11:7]};
               if (ea[IO_PAGE_BIT]) begin
                  exp_addr.push_back(ea);
                  exp_data.push_back(b);
               end else begin
                  mem[(ea >> 2) % DMEM_WORDS] = b;
               end
            end
            7'b1100011: begin
               wb = 1'b0;
               if (branch_ref(ins[14:12], a, b)) begin
                  next_pc = pc + {{20{ins[31]}}, ins[7], ins[30:25], ins[11:8], 1'b0};
               end
            end
            default: wb = 1'b0;
         endcase
         if (wb && ins[11:7] != 5'd0) x[ins[11:7]] = res;
         pc = next_pc;
         steps++;
      end
   endfunction

   task automatic abort_run();
      $display("FAIL: see errors above");
      $fatal(1);
   endtask

   task automatic compare_addr(word_t expected, word_t actual);
      if (actual !== expected) begin
         $display("[ERROR] %s: io_addr expected %h, actual %h", test_name, expected, actual);
         abort_run();
      end
   endtask

   task automatic compare_data(word_t expected, word_t actual);
      if (actual !== expected) begin
         $display("[ERROR] %s: io_wdata expected %h, actual %h", test_name, expected, actual);
         abort_run();
      end
   endtask

   always @(negedge clk) begin
      if ($isunknown(io_wr)) begin
         $display("io_wr is unknown in test %s", test_name);
         abort_run();
      end else if (io_wr) begin
         if (exp_addr.size() == 0) begin
            $display("unexpected IO store to %h in test %s", io_addr, test_name);
            abort_run();
         end else begin
            compare_addr(exp_addr.pop_front(), io_addr);
            compare_data(exp_data.pop_front(), io_wdata);
         end
      end
   end

   // reset goes high here, program is built while the core is held
   task automatic start_test(string name);
      @(negedge clk);
      resetn    = 1'b1;
      test_name = name;
      prog_len  = 0;
      put_wr(enc_u(20'h00400, 5'd31, 7'b0110111));  // x31 = 0x0040_0000
   endtask

   task automatic finish_test();
      int cycles;
      exp_addr.delete();
      exp_data.delete();
      run_model();
      repeat (16) @(negedge clk);
      resetn = 1'b0;
      cycles = 0;
      while (exp_addr.size() != 0) begin
         @(negedge clk);
         cycles++;
         if (cycles > TIMEOUT) begin
            $display("timeout in test %s, %0d IO stores never came", test_name,
                     exp_addr.size());
            abort_run();
         end
      end
   endtask

   task automatic test_reg_ops();
      start_test("reg_ops");
      for (int p = 0; p < 3; p++) begin
         load_const(5'd1, $random(seed));
         load_const(5'd2, $random(seed));
         for (int k = 0; k < 10; k++) begin
            // k 8 and 9 are sub and sra
            put_wr(enc_r({1'b0, k >= 8, 5'b0}, 5'd2, 5'd1,
                         funct3_t'((k == 9) ? 5 : (k == 8) ? 0 : k), 5'd3));
            store_io(5'd3, 12'(p * 64 + k * 4));
         end
      end
      finish_test();
   endtask

   task automatic test_imm_ops();
      word_t       v;
      logic [11:0] imm;
      start_test("imm_ops");
      for (int p = 0; p < 3; p++) begin
         v     = $random(seed);
         v[31] = (p != 1);  // negative operand for srai
         load_const(5'd1, v);
         for (int k = 0; k < 9; k++) begin
            imm = 12'($random(seed));
            if (k == 1 || k == 5) imm[11:5] = 7'b0;
            if (k == 8) imm[11:5] = 7'b0100000;  // srai
            put_wr(enc_i(imm, 5'd1, funct3_t'((k == 8) ? 5 : k), 5'd3, 7'b0010011));
            store_io(5'd3, 12'(p * 64 + k * 4));
         end
         put_wr(enc_u(20'($random(seed)), 5'd4, 7'b0110111));  // lui
         store_io(5'd4, 12'(p * 64 + 40));
         put_wr(enc_u(20'($random(seed)), 5'd5, 7'b0010111));  // auipc
         store_io(5'd5, 12'(p * 64 + 44));
      end
      finish_test();
   endtask

   task automatic test_branches();
      word_t a;
      word_t b;
      start_test("branches");
      for (int k = 0; k < 6; k++) begin
         a = $random(seed);
         b = $random(seed);
         // pairs (a,b), (b,a), (a,a)
         for (int p = 0; p < 3; p++) begin
            load_const(5'd1, a);
            load_const(5'd2, (p == 2) ? a : b);
            put(enc_b(13'd12, 5'd2, 5'd1, funct3_t'((k < 2) ? k : k + 2)));
            store_io(5'd1, 12'h100);  // fall-through marker
            put(NOP_INSTR);
            store_io(5'd2, 12'h104);  // target marker
            {a, b} = {b, a};
         end
      end
      finish_test();
   endtask

   task automatic test_jumps();
      int tgt;
      start_test("jumps");
      for (int p = 0; p < 2; p++) begin
         put(enc_j(21'd16, 5'd5));  // jal x5, +16
         store_io(5'd0, 12'h200);   // cancelled
         put(NOP_INSTR);
         put(NOP_INSTR);
         repeat (3) put(NOP_INSTR);
         store_io(5'd5, 12'h204);
         tgt = (prog_len + 8) * 4;  // addi, 3 NOPs, jalr, 3 skipped words
         put_wr(enc_i(12'(tgt - 2 - p * 8), 5'd0, 3'b000, 5'd6, 7'b0010011));
         put(enc_i(12'(3 + p * 8), 5'd6, 3'b000, 5'd7, 7'b1100111));  // odd sum
         store_io(5'd0, 12'h208);   // cancelled
         put(NOP_INSTR);
         put(NOP_INSTR);
         repeat (3) put(NOP_INSTR);
         store_io(5'd7, 12'h20c);
      end
      finish_test();
   endtask

   task automatic test_memory();
      logic [11:0] off [4];
      start_test("memory");
      for (int k = 0; k < 4; k++) begin
         off[k] = 12'(({$random(seed)} % 512) * 4);
         load_const(5'd8, $random(seed));
         put(enc_s(off[k], 5'd8, 5'd0));
      end
      for (int k = 0; k < 4; k++) begin
         put_wr(enc_i(off[k], 5'd0, 3'b010, 5'd10, 7'b0000011));  // lw
         store_io(5'd10, 12'(k * 4));
      end
      load_const(5'd11, $random(seed));
      put(enc_j(21'd12, 5'd0));
      put(enc_s(off[0], 5'd11, 5'd0));  // must not reach the RAM
      put(NOP_INSTR);
      put_wr(enc_i(off[0], 5'd0, 3'b010, 5'd10, 7'b0000011));
      store_io(5'd10, 12'h10);
      finish_test();
   endtask

   initial begin
      resetn = 1'b1;
      test_reg_ops();
      test_imm_ops();
      test_branches();
      test_jumps();
      test_memory();
      if (exp_addr.size() == 0) begin
         $display("PASS: all tests");
         $finish;
      end else begin
         $display("%0d IO stores left unchecked", exp_addr.size());
         abort_run();
      end
   end

endmodule

//--- verification/tb_rv_core_assert.sv
// tb_rv_core_assert
// concurrent checks on the IO strobe and the fetch redirect of rv_core

`timescale 1ns/1ns

module tb_rv_core_assert (
   input logic               clk,
   input logic               resetn,
   input logic               io_wr,
   input rv_pkg::word_t      io_addr,
   input rv_pkg::word_t      imem_data,
   input logic               redirect,
   input rv_pkg::word_t      redirect_pc,
   input rv_pkg::imem_addr_t imem_addr
);
   import rv_pkg::*;

   // quiet during reset and one cycle after
   io_quiet: assert property (@(posedge clk) $past(resetn) |-> !io_wr)
      else $error("io_wr high during reset or right after it");

   // an IO strobe comes from a store word fetched three cycles before
   io_page: assert property (@(posedge clk) disable iff (resetn)
      io_wr |-> io_addr[IO_PAGE_BIT] && $past(imem_data[6:0], 3) == 7'b0100011)
      else $error("io_wr outside the IO page or without a store fetched three cycles before");

   // fetch jumps to the target and the next two execute slots are bubbles
   fetch_target: assert property (@(posedge clk) disable iff (resetn)
      redirect |=> (imem_addr == $past(redirect_pc[15:2]) && !redirect) ##1 !redirect)
      else $error("redirect target not fetched or a cancelled slot redirected");

endmodule

//--- verilog/rv_core.sv
// rv_core
// five-stage RV32I pipeline top, fetch PC and fetch/decode register,
// program store is external and read combinationally

`timescale 1ns/1ns

module rv_core #(
   parameter int unsigned DMEM_WORDS = 1024
) (
   input  logic               clk,
   input  logic               resetn,
   output rv_pkg::imem_addr_t imem_addr,
   input  rv_pkg::word_t      imem_data,
   output rv_pkg::word_t      io_addr,
   output rv_pkg::word_t      io_wdata,
   output logic               io_wr
);
   import rv_pkg::*;

   word_t   pc;
   fd_t     fd;
   de_t     de;
   em_t     em;
   logic    redirect;
   word_t   redirect_pc;
   reg_id_t rs1_id;
   reg_id_t rs2_id;
   word_t   rs1_data;
   word_t   rs2_data;
   logic    wr_en;
   reg_id_t wr_id;
   word_t   wr_data;

   assign imem_addr = pc[15:2];

   always_ff @(posedge clk) begin
      if (resetn) begin
         pc <= '0;
         fd <= '{valid: 1'b0, pc: '0, instr: NOP_INSTR};
      end else begin
         pc       <= redirect ? redirect_pc : pc + 32'd4;
         fd.valid <= !redirect;  // the word fetched beside a redirect is dropped
         fd.pc    <= pc;
         fd.instr <= redirect ? NOP_INSTR : imem_data;
      end
   end

   rv_regfile i_rv_regfile (
      .clk      (clk),
      .rd1_id   (rs1_id),
      .rd2_id   (rs2_id),
      .rd1_data (rs1_data),
      .rd2_data (rs2_data),
      .wr_en    (wr_en),
      .wr_id    (wr_id),
      .wr_data  (wr_data)
   );

   rv_decode i_rv_decode (
      .clk(clk), .resetn(resetn), .fd(fd), .redirect(redirect),
      .rs1_id(rs1_id), .rs2_id(rs2_id), .rs1_data(rs1_data), .rs2_data(rs2_data),
      .de(de)
   );

   rv_execute i_rv_execute (
      .clk(clk), .resetn(resetn), .de(de),
      .redirect(redirect), .redirect_pc(redirect_pc), .em(em)
   );

   rv_memory #(.DMEM_WORDS(DMEM_WORDS)) i_rv_memory (
      .clk(clk), .resetn(resetn), .em(em),
      .io_addr(io_addr), .io_wdata(io_wdata), .io_wr(io_wr),
      .wr_en(wr_en), .wr_id(wr_id), .wr_data(wr_data)
   );

endmodule

//--- verilog/rv_memory.sv
// rv_memory
// memory and writeback stages, word data RAM, IO page stores
// and the register write port

`timescale 1ns/1ns

module rv_memory #(
   parameter int unsigned DMEM_WORDS = 1024
) (
   input  logic            clk,
   input  logic            resetn,
   input  rv_pkg::em_t     em,
   output rv_pkg::word_t   io_addr,
   output rv_pkg::word_t   io_wdata,
   output logic            io_wr,
   output logic            wr_en,
   output rv_pkg::reg_id_t wr_id,
   output rv_pkg::word_t   wr_data
);
   import rv_pkg::*;

   localparam int AW = $clog2(DMEM_WORDS);

   word_t         ram [DMEM_WORDS];
   logic [AW-1:0] ram_idx;
   logic          is_io;
   logic          ram_we;
   word_t         mdata;   // ram read data, lines up with mw
   mw_t           mw;

   assign ram_idx = em.addr[AW+1:2];
   assign is_io   = em.addr[IO_PAGE_BIT];
   assign ram_we  = em.valid && em.store && !is_io;

   assign io_addr  = em.addr;
   assign io_wdata = em.rs2;
   assign io_wr    = em.valid && em.store && is_io;

   always_ff @(posedge clk) begin
      mdata <= ram[ram_idx];
      if (ram_we) begin
         ram[ram_idx] <= em.rs2;
      end
   end

   always_ff @(posedge clk) begin
      mw <= '{valid: em.valid, rd: em.rd, wb_enable: em.wb_enable,
              load: em.load, result: em.result};
      if (resetn) begin
         mw.valid <= 1'b0;
      end
   end

   // writeback
   assign wr_en   = mw.valid && mw.wb_enable;
   assign wr_id   = mw.rd;
   assign wr_data = mw.load ? mdata : mw.result;

endmodule

//--- verilog/rv_execute.sv
// rv_execute
// execute stage: operand select, result and target, redirect of fetch

`timescale 1ns/1ns

module rv_execute (
   input  logic          clk,
   input  logic          resetn,
   input  rv_pkg::de_t   de,
   output logic          redirect,
   output rv_pkg::word_t redirect_pc,
   output rv_pkg::em_t   em
);
   import rv_pkg::*;

   word_t      alu_in2;
   logic [4:0] shamt;
   word_t      alu_out;
   logic       take_branch;
   word_t      pc_plus4;
   word_t      pc_plus_imm;
   word_t      rs1_plus_imm;
   em_t        em_nxt;

   assign alu_in2 = (de.alu_reg || de.branch) ? de.rs2 : de.imm;
   assign shamt   = de.alu_imm ? de.shamt : de.rs2[4:0];

   rv_alu i_rv_alu (
      .in1         (de.rs1),
      .in2         (alu_in2),
      .shamt       (shamt),
      .funct3      (de.funct3),
      .minus       (de.minus),
      .arith_shift (de.arith_shift),
      .result      (alu_out),
      .take_branch (take_branch)
   );

   assign pc_plus4     = de.pc + 32'd4;
   assign pc_plus_imm  = de.pc + de.imm;
   assign rs1_plus_imm = de.rs1 + de.imm;  // jalr target and load/store address

   // a bubble never redirects
   assign redirect    = de.valid && (de.jal || de.jalr || (de.branch && take_branch));
   assign redirect_pc = (de.branch || de.jal) ? pc_plus_imm : {rs1_plus_imm[31:1], 1'b0};

   always_comb begin
      em_nxt.valid     = de.valid;
      em_nxt.result    = (de.jal || de.jalr) ? pc_plus4    :
                         de.lui              ? de.imm      :
                         de.auipc            ? pc_plus_imm : alu_out;
      em_nxt.addr      = rs1_plus_imm;
      em_nxt.rs2       = de.rs2;
      em_nxt.rd        = de.rd;
      em_nxt.wb_enable = de.wb_enable;
      em_nxt.load      = de.load;
      em_nxt.store     = de.store;
   end

   always_ff @(posedge clk) begin
      em <= em_nxt;
      if (resetn) begin
         em.valid <= 1'b0;
      end
   end

endmodule

//--- verilog/rv_decode.sv
// rv_decode
// decode stage: classifies the instruction, builds the immediate
// and registers the bundle for execute

`timescale 1ns/1ns

module rv_decode (
   input  logic            clk,
   input  logic            resetn,
   input  rv_pkg::fd_t     fd,
   input  logic            redirect,
   output rv_pkg::reg_id_t rs1_id,
   output rv_pkg::reg_id_t rs2_id,
   input  rv_pkg::word_t   rs1_data,
   input  rv_pkg::word_t   rs2_data,
   output rv_pkg::de_t     de
);
   import rv_pkg::*;

   word_t      instr;
   logic [4:0] opcode;
   word_t      imm_u;
   word_t      imm_i;
   word_t      imm_s;
   word_t      imm_b;
   word_t      imm_j;
   de_t        de_nxt;
   de_t        de_q;

   assign instr  = fd.instr;
   assign opcode = instr[6:2];
   assign rs1_id = instr[19:15];
   assign rs2_id = instr[24:20];

   assign imm_u = {instr[31:12], 12'b0};
   assign imm_i = {{21{instr[31]}}, instr[30:20]};
   assign imm_s = {{21{instr[31]}}, instr[30:25], instr[11:7]};
   assign imm_b = {{20{instr[31]}}, instr[7], instr[30:25], instr[11:8], 1'b0};
   assign imm_j = {{12{instr[31]}}, instr[19:12], instr[20], instr[30:21], 1'b0};

   always_comb begin
      de_nxt.valid   = fd.valid && !redirect;  // squash the slot behind a jump
      de_nxt.pc      = fd.pc;
      de_nxt.rs1     = '0;  // filled from the bank read ports
      de_nxt.rs2     = '0;
      de_nxt.rd      = instr[11:7];
      de_nxt.alu_reg = (opcode == OP_ALU_REG);
      de_nxt.alu_imm = (opcode == OP_ALU_IMM);
      de_nxt.branch  = (opcode == OP_BRANCH);
      de_nxt.jal     = (opcode == OP_JAL);
      de_nxt.jalr    = (opcode == OP_JALR);
      de_nxt.auipc   = (opcode == OP_AUIPC);
      de_nxt.lui     = (opcode == OP_LUI);
      de_nxt.load    = (opcode == OP_LOAD);
      de_nxt.store   = (opcode == OP_STORE);
      de_nxt.funct3  = instr[14:12];
      de_nxt.minus   = instr[30] && de_nxt.alu_reg;  // sub only, not srai
      de_nxt.arith_shift = instr[30];
      de_nxt.shamt   = instr[24:20];
      de_nxt.wb_enable = !(de_nxt.branch || de_nxt.store) && (de_nxt.rd != '0);

      if (de_nxt.auipc || de_nxt.lui) begin
         de_nxt.imm = imm_u;
      end else if (de_nxt.alu_imm || de_nxt.jalr || de_nxt.load) begin
         de_nxt.imm = imm_i;
      end else if (de_nxt.store) begin
         de_nxt.imm = imm_s;
      end else if (de_nxt.branch) begin
         de_nxt.imm = imm_b;
      end else begin
         de_nxt.imm = imm_j;
      end
   end

   always_ff @(posedge clk) begin
      de_q <= de_nxt;
      if (resetn) begin
         de_q.valid <= 1'b0;
      end
   end

   // operands come from the bank read registers, loaded on the same edge
   always_comb begin
      de     = de_q;
      de.rs1 = rs1_data;
      de.rs2 = rs2_data;
   end

endmodule

//--- verilog/rv_alu.sv
// rv_alu
// integer ALU and branch condition, one adder, one 33-bit subtractor
// and a single right shifter reused for left shifts

`timescale 1ns/1ns

module rv_alu (
   input  rv_pkg::word_t   in1,
   input  rv_pkg::word_t   in2,
   input  logic [4:0]      shamt,
   input  rv_pkg::funct3_t funct3,
   input  logic            minus,
   input  logic            arith_shift,
   output rv_pkg::word_t   result,
   output logic            take_branch
);
   import rv_pkg::*;

   word_t              sum;
   logic [32:0]        diff;
   logic               lt;
   logic               ltu;
   logic               eq;
   word_t              in1_rev;
   word_t              shift_in;
   logic signed [32:0] shift_wide;
   word_t              shift_out;
   word_t              shift_rev;

   assign sum  = in1 + in2;
   assign diff = {1'b1, ~in2} + {1'b0, in1} + 33'd1;  // in1 - in2, borrow in bit 32
   assign ltu  = diff[32];
   assign lt   = (in1[31] ^ in2[31]) ? in1[31] : diff[32];
   assign eq   = (diff[31:0] == '0);

   // left shift = reverse, shift right, reverse back
   assign in1_rev    = {<<{in1}};
   assign shift_in   = (funct3 == 3'b001) ? in1_rev : in1;
   assign shift_wide = $signed({arith_shift & in1[31], shift_in}) >>> shamt;
   assign shift_out  = shift_wide[31:0];
   assign shift_rev  = {<<{shift_out}};

   always_comb begin
      case (funct3)
         3'b000:  result = minus ? diff[31:0] : sum;
         3'b001:  result = shift_rev;
         3'b010:  result = {31'b0, lt};
         3'b011:  result = {31'b0, ltu};
         3'b100:  result = in1 ^ in2;
         3'b101:  result = shift_out;
         3'b110:  result = in1 | in2;
         default: result = in1 & in2;
      endcase
   end

   always_comb begin
      case (funct3)
         3'b000:  take_branch = eq;    // beq
         3'b001:  take_branch = !eq;   // bne
         3'b100:  take_branch = lt;
         3'b101:  take_branch = !lt;
         3'b110:  take_branch = ltu;
         3'b111:  take_branch = !ltu;
         default: take_branch = 1'b0;
      endcase
   end

endmodule

//--- verilog/rv_regfile.sv
// rv_regfile
// 32 x 32 register bank, two registered read ports and one write port

`timescale 1ns/1ns

module rv_regfile (
   input  logic            clk,
   input  rv_pkg::reg_id_t rd1_id,
   input  rv_pkg::reg_id_t rd2_id,
   output rv_pkg::word_t   rd1_data,
   output rv_pkg::word_t   rd2_data,
   input  logic            wr_en,
   input  rv_pkg::reg_id_t wr_id,
   input  rv_pkg::word_t   wr_data
);
   import rv_pkg::*;

   word_t bank [32];

   // read before write on the same edge
   always_ff @(posedge clk) begin
      rd1_data <= (rd1_id == '0) ? '0 : bank[rd1_id];
      rd2_data <= (rd2_id == '0) ? '0 : bank[rd2_id];
   end

   always_ff @(posedge clk) begin
      if (wr_en && (wr_id != '0)) begin  // x0 stays zero
         bank[wr_id] <= wr_data;
      end
   end

endmodule

//--- verilog/rv_pkg.sv
// rv_pkg
// shared types, encodings and stage bundles of the five-stage RV32I core

package rv_pkg;

   typedef logic [31:0] word_t;       // data or address word
   typedef logic [4:0]  reg_id_t;     // register index
   typedef logic [2:0]  funct3_t;     // alu op or branch condition
   typedef logic [13:0] imem_addr_t;  // instruction word address

   // add x0,x0,x0
   localparam word_t NOP_INSTR = 32'h0000_0033;

   // address bit that selects the IO page
   localparam int IO_PAGE_BIT = 22;

   // instr[6:2] of the kept classes
   localparam logic [4:0] OP_ALU_REG = 5'b01100;
   localparam logic [4:0] OP_ALU_IMM = 5'b00100;
   localparam logic [4:0] OP_BRANCH  = 5'b11000;
   localparam logic [4:0] OP_JALR    = 5'b11001;
   localparam logic [4:0] OP_JAL     = 5'b11011;
   localparam logic [4:0] OP_AUIPC   = 5'b00101;
   localparam logic [4:0] OP_LUI     = 5'b01101;
   localparam logic [4:0] OP_LOAD    = 5'b00000;
   localparam logic [4:0] OP_STORE   = 5'b01000;

   // fetch to decode
   typedef struct packed {
      logic  valid;
      word_t pc;
      word_t instr;
   } fd_t;

   // decode to execute
   typedef struct packed {
      logic       valid;
      word_t      pc;
      word_t      rs1;
      word_t      rs2;
      word_t      imm;
      reg_id_t    rd;
      logic       wb_enable;
      logic       alu_reg;
      logic       alu_imm;
      logic       branch;
      logic       jal;
      logic       jalr;
      logic       auipc;
      logic       lui;
      logic       load;
      logic       store;
      funct3_t    funct3;
      logic       minus;        // sub instead of add
      logic       arith_shift;  // instr[30], sra vs srl
      logic [4:0] shamt;        // immediate shift amount
   } de_t;

   // execute to memory
   typedef struct packed {
      logic    valid;
      word_t   result;
      word_t   addr;     // load/store address
      word_t   rs2;      // store data
      reg_id_t rd;
      logic    wb_enable;
      logic    load;
      logic    store;
   } em_t;

   // memory to writeback
   typedef struct packed {
      logic    valid;
      reg_id_t rd;
      logic    wb_enable;
      logic    load;
      word_t   result;
   } mw_t;

endpackage
